// File: traffic_controller.f
+incdir+common
common/tlc_phase_pkg.sv
common/tlc_display_pkg.sv
src/tick_prescaler.sv
sequencer/request_latch.sv
sequencer/phase_sequencer.sv
display/signal_display.sv
src/traffic_controller_top.sv
bench/tb_traffic_controller.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_traffic_controller \
  -f traffic_controller.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log \
  && { echo "simulation result: FAIL"; exit 1; } \
  || { echo "simulation result: PASS"; exit 0; }

// File: bench/tb_traffic_controller.sv
`default_nettype none

`include "tlc_macros.svh"

module tb_traffic_controller;

  import tlc_display_pkg::*;

  localparam int tps         = 40;                 // clk_1 cycles per second, slow rate
  localparam int fast_p      = tps / `TLC_FAST_DIV; // cycles per second with fast high
  localparam int cycle_limit = 12000;              // tests need about 6400 cycles

  logic      clk_1 = 1'b0;
  logic      reset;
  logic      fast;
  logic      left_key;  // active low
  logic [1:0] walk_keys; // active low
  hex_bank_t hex;

  int     errors      = 0;
  int     checks      = 0;
  int     cycle_count = 0;
  integer seed        = 32'h65a7aba5; // picks key press moments
  string  test_name;

  // expected digit banks, one per visible phase
  hex_bank_t ew_green_v;
  hex_bank_t ew_amber_v;
  hex_bank_t all_red_v;
  hex_bank_t ns_green_v;
  hex_bank_t ns_amber_v;
  hex_bank_t ew_walk_v;
  hex_bank_t ns_walk_v;
  hex_bank_t ns_left_v;

  traffic_controller_top #(
    .ticks_per_second(tps)
  ) i_dut (
    .clk_1    (clk_1),
    .reset    (reset),
    .fast     (fast),
    .left_key (left_key),
    .walk_keys(walk_keys),
    .hex      (hex)
  );

  always #4 clk_1 = ~clk_1; // period 8

  always @(posedge clk_1)
  begin
    cycle_count++;
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  // lamp pairs and crossing pairs always agree, south may carry the arrow
  function automatic hex_bank_t view(input seg_t ns, input seg_t south, input seg_t ew,
                                     input seg_t ew_walk, input seg_t ns_walk);
    hex_bank_t b;
    b.north      = ns;
    b.south      = south;
    b.east       = ew;
    b.west       = ew;
    b.east_walk  = ew_walk;
    b.west_walk  = ew_walk;
    b.north_walk = ns_walk;
    b.south_walk = ns_walk;
    return b;
  endfunction

  task automatic check_seg(input string what, input seg_t expected, input seg_t actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("error %s %s: expected %b, actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic check_cycles(input string what, input int expected, input int actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  // counts falling edges until the digits show the wanted phase
  task automatic wait_bank(input string what, input hex_bank_t want, input int bound,
                           output int cycles);
    cycles = 0;
    while (hex !== want && cycles < bound)
    begin
      @(negedge clk_1);
      cycles++;
    end
    if (hex !== want)
    begin
      errors++;
      $display("%s: phase %s never arrived within %0d cycles", test_name, what, bound);
    end
  endtask

  task automatic apply_reset(input logic fast_on);
    fast      = fast_on;
    left_key  = 1'b1;
    walk_keys = 2'b11;
    reset     = 1'b0;
    repeat (2) @(negedge clk_1);
    reset = 1'b1; // released on a falling edge
  endtask

  task automatic press_keys(input logic left, input logic [1:0] walk);
    left_key  = ~left;
    walk_keys = ~walk;
    repeat (4) @(negedge clk_1); // longer than the synchronizer
    left_key  = 1'b1;
    walk_keys = 2'b11;
  endtask

  task automatic random_pause(input int range);
    int n;
    n = {$random(seed)} % range;
    repeat (n) @(negedge clk_1);
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  task automatic reset_and_green();
    int n;
    test_name = "reset_and_green";
    apply_reset(1'b1);
    check_seg("east", `TLC_SEG_GREEN, hex.east);
    check_seg("west", `TLC_SEG_GREEN, hex.west);
    check_seg("north", `TLC_SEG_RED, hex.north);
    check_seg("south", `TLC_SEG_RED, hex.south);
    check_seg("east walk", `TLC_SEG_DONT_WALK, hex.east_walk);
    check_seg("west walk", `TLC_SEG_DONT_WALK, hex.west_walk);
    check_seg("north walk", `TLC_SEG_DONT_WALK, hex.north_walk);
    check_seg("south walk", `TLC_SEG_DONT_WALK, hex.south_walk);
    wait_bank("ew_amber", ew_amber_v, 400, n);
    check_cycles("ew green", `TLC_T_GREEN * fast_p, n);
  endtask

  task automatic plain_cycle();
    int n;
    test_name = "plain_cycle";
    apply_reset(1'b1);
    wait_bank("ew_amber", ew_amber_v, 400, n);
    wait_bank("all_red_a", all_red_v, 100, n);
    check_cycles("ew amber", `TLC_T_AMBER * fast_p, n);
    wait_bank("ns_green", ns_green_v, 100, n);
    check_cycles("all red a", `TLC_T_ALL_RED * fast_p, n);
    wait_bank("ns_amber", ns_amber_v, 400, n);
    check_cycles("ns green", `TLC_T_GREEN * fast_p, n);
    wait_bank("all_red_b", all_red_v, 100, n);
    check_cycles("ns amber", `TLC_T_AMBER * fast_p, n);
    wait_bank("ew_green", ew_green_v, 100, n);
    check_cycles("all red b", `TLC_T_ALL_RED * fast_p, n);
    wait_bank("ew_amber", ew_amber_v, 400, n);
    check_cycles("ew green", `TLC_T_GREEN * fast_p, n);
  endtask

  task automatic east_west_walk();
    int n;
    int not_green;
    test_name = "east_west_walk";
    not_green = 0;
    apply_reset(1'b1);
    wait_bank("ns_green", ns_green_v, 400, n);
    random_pause(200);
    press_keys(1'b0, ({$random(seed)} % 2 == 0) ? 2'b01 : 2'b10);
    wait_bank("ew_walk", ew_walk_v, 400, n);
    wait_bank("ew_flash", ew_green_v, 100, n); // flash opens with the hand lit
    check_cycles("ew walk", `TLC_T_WALK * fast_p, n);
    repeat ((`TLC_T_FLASH + `TLC_T_DONT_WALK) * fast_p)
    begin
      if (hex.east !== `TLC_SEG_GREEN || hex.west !== `TLC_SEG_GREEN)
        not_green++;
      @(negedge clk_1);
    end
    check_cycles("cycles without ew green", 0, not_green);
    wait_bank("ew_amber", ew_amber_v, 4, n);
    check_cycles("amber after dont walk", 0, n);
    // next cycle has no press, so plain green
    wait_bank("ns_green", ns_green_v, 400, n);
    wait_bank("ew_green", ew_green_v, 400, n);
    wait_bank("ew_amber", ew_amber_v, 400, n);
    check_cycles("ew green without walk", `TLC_T_GREEN * fast_p, n);
  endtask

  task automatic flash_pattern();
    int   n;
    seg_t expected;
    test_name = "flash_pattern";
    apply_reset(1'b1);
    wait_bank("ns_green", ns_green_v, 400, n);
    random_pause(200);
    press_keys(1'b0, 2'b01);
    wait_bank("ew_walk", ew_walk_v, 400, n);
    wait_bank("ew_flash", ew_green_v, 100, n);
    for (int i = 0; i < 16; i++)
    begin
      expected = ((i / 2) % 2 == 0) ? `TLC_SEG_DONT_WALK : `TLC_SEG_DARK; // half second is 2
      check_seg("east walk", expected, hex.east_walk);
      check_seg("west walk", expected, hex.west_walk);
      @(negedge clk_1);
    end
  endtask

  task automatic left_turn();
    int n;
    test_name = "left_turn";
    apply_reset(1'b1);
    random_pause(200); // stays inside ew green
    press_keys(1'b1, 2'b00);
    wait_bank("all_red_a", all_red_v, 400, n);
    wait_bank("ns_left", ns_left_v, 100, n);
    check_cycles("all red a", `TLC_T_ALL_RED * fast_p, n);
    wait_bank("ns_green", ns_green_v, 200, n);
    check_cycles("left arrow", `TLC_T_LEFT * fast_p, n);
    // both keys together
    apply_reset(1'b1);
    random_pause(200);
    press_keys(1'b1, 2'b10);
    wait_bank("ns_left", ns_left_v, 400, n);
    wait_bank("ns_walk", ns_walk_v, 200, n);
    check_cycles("left arrow before walk", `TLC_T_LEFT * fast_p, n);
  endtask

  task automatic slow_rate();
    int n;
    test_name = "slow_rate";
    apply_reset(1'b0);
    wait_bank("ew_amber", ew_amber_v, `TLC_T_GREEN * tps + 100, n);
    wait_bank("all_red_a", all_red_v, 400, n);
    check_cycles("ew amber", `TLC_T_AMBER * tps, n);
  endtask

  ////////////////////////////////////////
  // run
  ////////////////////////////////////////
  initial
  begin
    reset      = 1'b0;
    fast       = 1'b1;
    left_key   = 1'b1;
    walk_keys  = 2'b11;
    ew_green_v = view(`TLC_SEG_RED, `TLC_SEG_RED, `TLC_SEG_GREEN,
                      `TLC_SEG_DONT_WALK, `TLC_SEG_DONT_WALK);
    ew_amber_v = view(`TLC_SEG_RED, `TLC_SEG_RED, `TLC_SEG_AMBER,
                      `TLC_SEG_DONT_WALK, `TLC_SEG_DONT_WALK);
    all_red_v  = view(`TLC_SEG_RED, `TLC_SEG_RED, `TLC_SEG_RED,
                      `TLC_SEG_DONT_WALK, `TLC_SEG_DONT_WALK);
    ns_green_v = view(`TLC_SEG_GREEN, `TLC_SEG_GREEN, `TLC_SEG_RED,
                      `TLC_SEG_DONT_WALK, `TLC_SEG_DONT_WALK);
    ns_amber_v = view(`TLC_SEG_AMBER, `TLC_SEG_AMBER, `TLC_SEG_RED,
                      `TLC_SEG_DONT_WALK, `TLC_SEG_DONT_WALK);
    ew_walk_v  = view(`TLC_SEG_RED, `TLC_SEG_RED, `TLC_SEG_GREEN,
                      `TLC_SEG_WALK, `TLC_SEG_DONT_WALK);
    ns_walk_v  = view(`TLC_SEG_GREEN, `TLC_SEG_GREEN, `TLC_SEG_RED,
                      `TLC_SEG_DONT_WALK, `TLC_SEG_WALK);
    ns_left_v  = view(`TLC_SEG_RED, `TLC_SEG_LEFT, `TLC_SEG_RED,
                      `TLC_SEG_DONT_WALK, `TLC_SEG_DONT_WALK);
    @(negedge clk_1);
    reset_and_green();
    plain_cycle();
    east_west_walk();
    flash_pattern();
    left_turn();
    slow_rate();
    $display("summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/traffic_controller_top.sv
`default_nettype none

module traffic_controller_top #(
  parameter int ticks_per_second = 27000000 // multiple of 20
) (
  input  wire                        clk_1,
  input  wire                        reset,
  input  wire                        fast,      // short seconds for bench work
  input  wire                        left_key,  // active low
  input  wire  [1:0]                 walk_keys, // active low
  output tlc_display_pkg::hex_bank_t hex
);

  import tlc_phase_pkg::*;

  logic     sec_tick;
  logic     half_tick;
  request_t requests;    // pending walk and left turn
  phase_t   phase;
  logic     phase_entry;

  tick_prescaler #(
    .ticks_per_second(ticks_per_second)
  ) i_prescaler (
    .clk_1    (clk_1),
    .reset    (reset),
    .fast     (fast),
    .sec_tick (sec_tick),
    .half_tick(half_tick)
  );

  request_latch i_requests (
    .clk_1      (clk_1),
    .reset      (reset),
    .left_key   (left_key),
    .walk_keys  (walk_keys),
    .phase      (phase),
    .phase_entry(phase_entry),
    .requests   (requests)
  );

  phase_sequencer i_sequencer (
    .clk_1      (clk_1),
    .reset      (reset),
    .sec_tick   (sec_tick),
    .requests   (requests),
    .phase      (phase),
    .phase_entry(phase_entry)
  );

  signal_display i_display (
    .clk_1      (clk_1),
    .reset      (reset),
    .half_tick  (half_tick),
    .phase      (phase),
    .phase_entry(phase_entry),
    .hex        (hex)
  );

endmodule

`default_nettype wire

// File: display/signal_display.sv
`default_nettype none

`include "tlc_macros.svh"

module signal_display (
  input  wire                       clk_1,
  input  wire                       reset,
  input  wire                       half_tick,   // flash rate
  input  wire  tlc_phase_pkg::phase_t phase,
  input  wire                       phase_entry,
  output tlc_display_pkg::hex_bank_t hex
);

  import tlc_phase_pkg::*;
  import tlc_display_pkg::*;

  logic blink;   // 1 shows the hand while flashing, 0 dark
  seg_t ns_lamp; // north-south lamp pattern
  seg_t ew_lamp; // east-west lamp pattern

  // walk digit of one crossing
  function automatic seg_t walk_digit(
    input logic walking,
    input logic flashing,
    input logic blink_on
  );
    seg_t s;
    if (walking)
      s = `TLC_SEG_WALK;
    else if (flashing && !blink_on)
      s = `TLC_SEG_DARK;
    else
      s = `TLC_SEG_DONT_WALK;
    return s;
  endfunction

  ////////////////////////////////////////
  // flashing hand
  ////////////////////////////////////////
  always_ff @(posedge clk_1 or negedge reset)
  begin
    if (!reset)
      blink <= 1'b1;
    else if (phase_entry)
      blink <= 1'b1; // every flash phase starts lit
    else if (half_tick && ((phase == ew_flash) || (phase == ns_flash)))
      blink <= ~blink;
  end

  ////////////////////////////////////////
  // lamp and walk digits
  ////////////////////////////////////////
  always_comb
  begin
    case (phase)
      ns_walk, ns_flash, ns_dont_walk, ns_green: ns_lamp = `TLC_SEG_GREEN;
      ns_amber:                                  ns_lamp = `TLC_SEG_AMBER;
      default:                                   ns_lamp = `TLC_SEG_RED;
    endcase
    case (phase)
      ew_green, ew_walk, ew_flash, ew_dont_walk: ew_lamp = `TLC_SEG_GREEN;
      ew_amber:                                  ew_lamp = `TLC_SEG_AMBER;
      default:                                   ew_lamp = `TLC_SEG_RED;
    endcase
    hex.north      = ns_lamp;
    hex.south      = (phase == ns_left) ? `TLC_SEG_LEFT : ns_lamp; // arrow overrides red
    hex.east       = ew_lamp;
    hex.west       = ew_lamp;
    hex.east_walk  = walk_digit(phase == ew_walk, phase == ew_flash, blink);
    hex.west_walk  = walk_digit(phase == ew_walk, phase == ew_flash, blink);
    hex.north_walk = walk_digit(phase == ns_walk, phase == ns_flash, blink);
    hex.south_walk = walk_digit(phase == ns_walk, phase == ns_flash, blink);
  end

endmodule

`default_nettype wire

// File: sequencer/phase_sequencer.sv
`default_nettype none

`include "tlc_macros.svh"

module phase_sequencer (
  input  wire                     clk_1,
  input  wire                     reset,
  input  wire                     sec_tick,    // one second elapsed
  input  wire  tlc_phase_pkg::request_t requests,
  output tlc_phase_pkg::phase_t   phase,
  output logic                    phase_entry  // first cycle of a new phase
);

  import tlc_phase_pkg::*;

  phase_t next_phase; // phase that follows the current one
  timer_t timer;      // seconds left, 1 means last second
  logic   phase_done;

  // length of each phase in seconds
  function automatic timer_t duration(input phase_t p);
    timer_t d;
    case (p)
      ew_green, ns_green:         d = timer_t'(`TLC_T_GREEN);
      ew_amber, ns_amber:         d = timer_t'(`TLC_T_AMBER);
      ns_left:                    d = timer_t'(`TLC_T_LEFT);
      ew_walk, ns_walk:           d = timer_t'(`TLC_T_WALK);
      ew_flash, ns_flash:         d = timer_t'(`TLC_T_FLASH);
      ew_dont_walk, ns_dont_walk: d = timer_t'(`TLC_T_DONT_WALK);
      default:                    d = timer_t'(`TLC_T_ALL_RED); // both all red phases
    endcase
    return d;
  endfunction

  ////////////////////////////////////////
  // transition rules
  ////////////////////////////////////////
  always_comb
  begin
    case (phase)
      ew_green, ew_dont_walk: next_phase = ew_amber;
      ew_amber:               next_phase = all_red_a;
      all_red_a:
      begin
        if (requests.left_turn)
          next_phase = ns_left;  // left arrow first
        else if (requests.walk)
          next_phase = ns_walk;
        else
          next_phase = ns_green;
      end
      ns_left:                next_phase = requests.walk ? ns_walk : ns_green;
      ns_walk:                next_phase = ns_flash;
      ns_flash:               next_phase = ns_dont_walk;
      ns_green, ns_dont_walk: next_phase = ns_amber;
      ns_amber:               next_phase = all_red_b;
      all_red_b:              next_phase = requests.walk ? ew_walk : ew_green;
      ew_walk:                next_phase = ew_flash;
      ew_flash:               next_phase = ew_dont_walk;
      default:                next_phase = all_red_b; // stray code, stop everyone first
    endcase
  end

  assign phase_done = sec_tick && (timer == timer_t'(1)); // last second just ran out

  ////////////////////////////////////////
  // phase register and second timer
  ////////////////////////////////////////
  always_ff @(posedge clk_1 or negedge reset)
  begin
    if (!reset)
    begin
      phase       <= ew_green;
      timer       <= timer_t'(`TLC_T_GREEN);
      phase_entry <= 1'b0;
    end
    else
    begin
      phase_entry <= phase_done;
      if (phase_done)
      begin
        phase <= next_phase;
        timer <= duration(next_phase); // full duration for the new phase
      end
      else if (sec_tick)
        timer <= timer - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: sequencer/request_latch.sv
`default_nettype none

module request_latch (
  input  wire                     clk_1,
  input  wire                     reset,
  input  wire                     left_key,    // active low
  input  wire  [1:0]              walk_keys,   // active low, one per crossing
  input  wire  tlc_phase_pkg::phase_t phase,
  input  wire                     phase_entry,
  output tlc_phase_pkg::request_t requests
);

  import tlc_phase_pkg::*;

  logic [2:0] key_meta; // first synchronizer stage, {left, walk}
  logic [2:0] key_sync; // second stage, safe to use
  logic       walk_set;
  logic       left_set;
  logic       walk_clear;
  logic       left_clear;

  ////////////////////////////////////////
  // key synchronizer
  ////////////////////////////////////////
  always_ff @(posedge clk_1 or negedge reset)
  begin
    if (!reset)
    begin
      key_meta <= 3'b111; // keys idle high
      key_sync <= 3'b111;
    end
    else
    begin
      key_meta <= {left_key, walk_keys};
      key_sync <= key_meta;
    end
  end

  assign walk_set   = ~key_sync[1] | ~key_sync[0]; // either crossing
  assign left_set   = ~key_sync[2];
  assign walk_clear = phase_entry && ((phase == ew_walk) || (phase == ns_walk));
  assign left_clear = phase_entry && (phase == ns_left);

  // a press in the clearing cycle survives
  always_ff @(posedge clk_1 or negedge reset)
  begin
    if (!reset)
      requests <= '0;
    else
    begin
      requests.walk      <= walk_set | (requests.walk & ~walk_clear);
      requests.left_turn <= left_set | (requests.left_turn & ~left_clear);
    end
  end

endmodule

`default_nettype wire

// File: src/tick_prescaler.sv
`default_nettype none

`include "tlc_macros.svh"

module tick_prescaler #(
  parameter int ticks_per_second = 27000000 // clk_1 cycles in one real second
) (
  input  wire  clk_1,
  input  wire  reset,
  input  wire  fast,      // ten times faster seconds
  output logic sec_tick,  // one cycle pulse per second
  output logic half_tick  // one cycle pulse per half second
);

  localparam int cnt_w = $clog2(ticks_per_second);
  localparam int fast_period = ticks_per_second / `TLC_FAST_DIV;
  localparam logic [cnt_w-1:0] slow_last = cnt_w'(ticks_per_second - 1);
  localparam logic [cnt_w-1:0] slow_half = cnt_w'(ticks_per_second / 2 - 1);
  localparam logic [cnt_w-1:0] fast_last = cnt_w'(fast_period - 1);
  localparam logic [cnt_w-1:0] fast_half = cnt_w'(fast_period / 2 - 1);

  logic [cnt_w-1:0] cnt;    // position inside the current second
  logic             fast_q; // rate held for the rest of the period
  logic             fast_sel;
  logic [cnt_w-1:0] last;
  logic [cnt_w-1:0] half;
  logic             wrap;

  assign fast_sel  = (cnt == '0) ? fast : fast_q; // rate picked at period start
  assign last      = fast_sel ? fast_last : slow_last;
  assign half      = fast_sel ? fast_half : slow_half;
  assign wrap      = (cnt == last);
  assign sec_tick  = wrap;                  // taken at the edge that ends the period
  assign half_tick = wrap || (cnt == half); // twice per period

  always_ff @(posedge clk_1 or negedge reset)
  begin
    if (!reset)
    begin
      cnt    <= '0;
      fast_q <= 1'b0;
    end
    else
    begin
      fast_q <= fast_sel;
      if (wrap)
        cnt <= '0;
      else
        cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: common/tlc_display_pkg.sv
`default_nettype none

package tlc_display_pkg;

  typedef logic [6:0] seg_t; // one digit, active low, bit 6 is g

  ////////////////////////////////////////
  // digit bank, msb field is the leftmost digit
  ////////////////////////////////////////
  typedef struct packed {
    seg_t north;      // hex7, northbound lamp
    seg_t north_walk; // hex6
    seg_t south;      // hex5, southbound lamp and left arrow
    seg_t south_walk; // hex4
    seg_t east;       // hex3, eastbound lamp
    seg_t west_walk;  // hex2
    seg_t west;       // hex1, westbound lamp
    seg_t east_walk;  // hex0
  } hex_bank_t;

  // lamp digits of one axis carry the same pattern, except
  // the southbound digit while the left arrow is on

endpackage

`default_nettype wire

// File: common/tlc_phase_pkg.sv
`default_nettype none

package tlc_phase_pkg;

  ////////////////////////////////////////
  // controller phases
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    ew_green,     // east-west through, no crossing
    ew_walk,      // east-west green, crossing on walk
    ew_flash,     // east-west green, crossing flashes
    ew_dont_walk, // east-west green, crossing closed
    ew_amber,     // east-west clearing
    all_red_a,    // hand over to north-south
    ns_left,      // southbound protected left
    ns_walk,      // north-south green, crossing on walk
    ns_flash,     // north-south green, crossing flashes
    ns_dont_walk, // north-south green, crossing closed
    ns_green,     // north-south through, no crossing
    ns_amber,     // north-south clearing
    all_red_b     // hand over to east-west
  } phase_t;

  typedef logic [5:0] timer_t; // seconds left in the phase

  // requests waiting to be served
  typedef struct packed {
    logic walk;      // any pedestrian key
    logic left_turn; // southbound left key
  } request_t;

endpackage

`default_nettype wire

// File: common/tlc_macros.svh
`ifndef TLC_MACROS_SVH
`define TLC_MACROS_SVH

////////////////////////////////////////
// phase durations in seconds
////////////////////////////////////////
`define TLC_T_GREEN     60 // through traffic, either axis
`define TLC_T_AMBER     6  // clearance before all red
`define TLC_T_ALL_RED   2  // both axes stopped
`define TLC_T_LEFT      20 // protected southbound left
`define TLC_T_WALK      10 // steady walk
`define TLC_T_FLASH     20 // flashing do not walk
`define TLC_T_DONT_WALK 30 // rest of the green after the crossing

`define TLC_FAST_DIV 10 // fast switch makes a second this much shorter

////////////////////////////////////////
// seven segment patterns, active low, bit 6 is segment g
////////////////////////////////////////
`define TLC_SEG_RED       7'b1111110 // top bar
`define TLC_SEG_GREEN     7'b1110111 // bottom bar
`define TLC_SEG_AMBER     7'b0111111 // middle bar
`define TLC_SEG_LEFT      7'b0111001 // arrow pointing left
`define TLC_SEG_DARK      7'b1111111 // all segments off
`define TLC_SEG_WALK      7'b1011111 // walking figure
`define TLC_SEG_DONT_WALK 7'b0100001 // raised hand

`endif
